/* fq_handler.f */
source/fq_record_pkg.sv
source/fq_axi_pkg.sv
source/fq_event_fifo.sv
source/fq_record_builder.sv
source/fq_queue_ctrl.sv
source/fq_axi_writer.sv
source/fq_handler.sv
testbench/tb_clk_gen.sv
testbench/tb_fq_handler.sv

/* Bender.yml */
package:
  name: fq_handler

sources:
  - source/fq_record_pkg.sv
  - source/fq_axi_pkg.sv
  - source/fq_event_fifo.sv
  - source/fq_record_builder.sv
  - source/fq_queue_ctrl.sv
  - source/fq_axi_writer.sv
  - source/fq_handler.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_fq_handler.sv

/* testbench/tb_fq_handler.sv */
//******************************
// Testbench for the fault queue writer
// AXI memory slave with random ready delays, queue register model
// Directed faults for enable, records, stalls, overflow and bus errors
//******************************
`timescale 1ns/100ps

module tb_fq_handler import fq_record_pkg::*, fq_axi_pkg::*; ();

    logic               clk_i, rst_ni;
    logic [PPN_W-1:0]   fq_base_ppn_i;
    logic [4:0]         fq_size_i;
    logic               fq_en_i, fq_ie_i, fq_mf_i, fq_of_i;
    logic [IDX_W-1:0]   fq_head_i, fq_tail_i, fq_tail_o;
    logic               fq_mf_o, fq_of_o, error_wen_o, fq_ip_o, fq_on_o, busy_o;
    logic               event_valid_i, pv_i, is_supervisor_i, is_guest_pf_i, is_implicit_i;
    logic [TTYP_W-1:0]  trans_type_i;
    logic [CAUSE_W-1:0] cause_code_i;
    logic [VLEN-1:0]    iova_i;
    logic [GPA_W-1:0]   gpaddr_i;
    logic [DID_W-1:0]   did_i;
    logic [PID_W-1:0]   pid_i;
    logic               full_o;
    logic               aw_valid_o, aw_ready_i, w_valid_o, w_ready_i, w_last_o;
    logic               b_valid_i, b_ready_o;
    logic [PLEN-1:0]    aw_addr_o;
    logic [BEAT_W-1:0]  w_data_o;
    logic [1:0]         b_resp_i;

    int               seed, aw_count, wen_count, ip_count;
    int               aw_wait, w_wait, b_wait;   // Slave ready delays in cycles
    logic [1:0]       beat_idx;
    logic             b_pend, stall, err_resp;
    logic [255:0]     cur_rec;
    logic [255:0]     exp_rec [$];               // Beat n at bits 64n+63:64n
    logic [PLEN-1:0]  exp_addr [$];
    logic             m_wen, m_ip, m_mf, m_of;
    logic [IDX_W-1:0] m_tail;

    tb_clk_gen i_clk_gen (.clk_o (clk_i), .rst_no (rst_ni));

    fq_handler i_dut (.*);

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic report_failure(input string msg);
        $display("%0t ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
        abort_run();
    endtask

    task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else report_mismatch(name, exp, act);
    endtask

    // Record as software should read it from memory
    function automatic logic [255:0] expected_record();
        logic        has_tr;
        logic [63:0] b0, b2, b3;
        has_tr = (trans_type_i != TTYP_NONE);
        b0 = {did_i & {DID_W{has_tr}}, trans_type_i, has_tr & pv_i & is_supervisor_i,
              has_tr & pv_i, pid_i & {PID_W{has_tr & pv_i}}, cause_code_i};
        b2 = 64'(iova_i);
        b3 = is_guest_pf_i ? {23'd0, gpaddr_i[40:2], 1'b0, is_implicit_i} : 64'd0;
        return {b3, b2, 64'd0, b0};   // Beat 1 is reserved and all zero
    endfunction

    task automatic next_drive();
        @(posedge clk_i);
        #2;
    endtask

    task automatic wait_writes(input int target);
        int cycles;
        cycles = 0;
        while (wen_count < target) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > 300) report_failure("Timed out waiting for a queue register update");
        end
    endtask

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        while (rst_ni !== 1'b1) begin
            @(posedge clk_i);
            cycles++;
            if (cycles > 20) report_failure("Reset was never released");
        end
    endtask

    // One fault with random data fields and its expected queue slot
    task automatic drive_fault(input logic [TTYP_W-1:0] ttyp, input logic pv, input logic sup,
                               input logic guest, input logic impl, input logic written,
                               input logic [IDX_W-1:0] slot);
        next_drive();
        event_valid_i   = 1'b1;
        trans_type_i    = ttyp;
        cause_code_i    = CAUSE_W'($random(seed));
        iova_i          = VLEN'({$random(seed), $random(seed)});
        gpaddr_i        = GPA_W'({$random(seed), $random(seed)});
        did_i           = DID_W'($random(seed));
        pid_i           = PID_W'($random(seed));
        pv_i            = pv;
        is_supervisor_i = sup;
        is_guest_pf_i   = guest;
        is_implicit_i   = impl;
        if (written) begin
            exp_addr.push_back(PLEN'(fq_base_ppn_i) * 4096 + PLEN'(slot) * 32);
            exp_rec.push_back(expected_record());
        end
        next_drive();
        event_valid_i = 1'b0;   // Next fault needs a fresh rising edge
    endtask

    // Queue register model written by the DUT on error_wen_o
    always begin
        @(negedge clk_i);
        m_wen  = error_wen_o;
        m_ip   = fq_ip_o;
        m_tail = fq_tail_o;
        m_mf   = fq_mf_o;
        m_of   = fq_of_o;
        next_drive();
        if (m_wen) begin
            fq_tail_i = m_tail;
            fq_mf_i   = m_mf;
            fq_of_i   = m_of;
            wen_count++;
        end
        if (m_ip) ip_count++;
    end

    // AXI memory slave that checks each handshake against the expected records
    always begin
        @(negedge clk_i);
        if (aw_valid_o && aw_ready_i) begin
            aw_count++;
            if (exp_addr.size() == 0) report_failure("AW burst with no record pending");
            else check_eq("aw_addr_o", 64'(exp_addr.pop_front()), 64'(aw_addr_o));
            aw_wait = {$random(seed)} % 4;
        end
        if (w_valid_o && w_ready_i) begin
            if (beat_idx == 2'd0) begin
                if (exp_rec.size() == 0) report_failure("W beat with no record pending");
                else cur_rec = exp_rec.pop_front();
            end
            check_eq("w_data_o", cur_rec[64*beat_idx +: 64], w_data_o);
            check_eq("w_last_o", 64'(beat_idx == 2'd3), 64'(w_last_o));
            if (beat_idx == 2'd3) begin
                b_pend = 1'b1;
                b_wait = {$random(seed)} % 4;
            end
            beat_idx = beat_idx + 2'd1;
            w_wait   = {$random(seed)} % 4;
        end
        if (b_valid_i && b_ready_o) begin
            b_pend   = 1'b0;
            err_resp = 1'b0;                // Error only for one burst
        end
        next_drive();
        aw_ready_i = aw_valid_o && !stall && aw_wait == 0;
        if (aw_valid_o && !stall && aw_wait != 0) aw_wait--;
        w_ready_i = w_valid_o && !stall && w_wait == 0;
        if (w_valid_o && !stall && w_wait != 0) w_wait--;
        b_valid_i = b_pend && !stall && b_wait == 0;   // Held until b_ready_o
        b_resp_i  = err_resp ? RESP_SLVERR : RESP_OKAY;
        if (b_pend && !stall && b_wait != 0) b_wait--;
    end

    // Bus protocol and interrupt rules
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o))
        else report_failure("AW valid dropped or address changed before ready");
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o) && $stable(w_last_o))
        else report_failure("W valid dropped or data changed before ready");
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        fq_ip_o |-> error_wen_o && fq_ie_i)
        else report_failure("Interrupt raised without a register write or enable");

    initial begin
        seed = 55;
        {aw_count, wen_count, ip_count, aw_wait, w_wait, b_wait} = '0;
        {beat_idx, b_pend, stall, err_resp} = '0;
        {aw_ready_i, w_ready_i, b_valid_i, b_resp_i} = '0;
        {event_valid_i, trans_type_i, cause_code_i, iova_i, gpaddr_i} = '0;
        {did_i, pv_i, pid_i, is_supervisor_i, is_guest_pf_i, is_implicit_i} = '0;
        fq_base_ppn_i = 44'h876_5432_10a;
        fq_size_i     = 5'd4;               // 32 entries
        fq_head_i     = 32'd20;
        fq_tail_i     = 32'd7;              // Stale state that the enable clears
        fq_mf_i       = 1'b1;
        fq_of_i       = 1'b1;
        fq_ie_i       = 1'b1;
        fq_en_i       = 1'b0;
        wait_reset();
        @(negedge clk_i);
        check_eq("aw_valid_o", 0, aw_valid_o);
        check_eq("w_valid_o", 0, w_valid_o);
        check_eq("b_ready_o", 0, b_ready_o);
        check_eq("error_wen_o", 0, error_wen_o);
        check_eq("fq_ip_o", 0, fq_ip_o);
        check_eq("fq_on_o", 0, fq_on_o);
        check_eq("busy_o", 0, busy_o);

        // Enable gives one busy cycle and clears tail, mf and of
        next_drive();
        fq_en_i = 1'b1;
        @(negedge clk_i);
        check_eq("busy_o", 1, busy_o);
        check_eq("error_wen_o", 1, error_wen_o);
        check_eq("fq_tail_o", 0, fq_tail_o);
        check_eq("fq_mf_o", 0, fq_mf_o);
        check_eq("fq_of_o", 0, fq_of_o);
        @(negedge clk_i);
        check_eq("busy_o", 0, busy_o);
        check_eq("fq_on_o", 1, fq_on_o);
        check_eq("fq_tail_i", 0, fq_tail_i);

        // Guest page fault then a fault with no transaction
        drive_fault(TTYP_UNTR_WR, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 0);
        wait_writes(2);
        check_eq("fq_tail_i", 1, fq_tail_i);
        check_eq("ip_count", 1, ip_count);
        next_drive();
        fq_ie_i = 1'b0;                     // Interrupts masked for this record
        drive_fault(TTYP_NONE, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1);
        wait_writes(3);
        check_eq("fq_tail_i", 2, fq_tail_i);
        check_eq("ip_count", 1, ip_count);
        next_drive();
        fq_ie_i = 1'b1;

        // Three faults queued behind a stalled bus
        next_drive();
        stall = 1'b1;
        drive_fault(TTYP_UNTR_READ, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 2);
        drive_fault(TTYP_UNTR_RX, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 3);
        drive_fault(TTYP_UNTR_WR, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 4);
        check_eq("aw_valid_o", 1, aw_valid_o);     // First burst held at AW
        next_drive();
        stall = 1'b0;
        wait_writes(6);
        check_eq("fq_tail_i", 5, fq_tail_i);

        // Full queue drops a fault with overflow and holds the next ones until of clears
        next_drive();
        fq_head_i = 32'd6;
        drive_fault(TTYP_UNTR_READ, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 0);
        wait_writes(7);
        check_eq("fq_of_i", 1, fq_of_i);
        check_eq("fq_tail_i", 5, fq_tail_i);
        drive_fault(TTYP_UNTR_WR, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 5);
        drive_fault(TTYP_UNTR_RX, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 6);
        drive_fault(TTYP_NONE, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 7);
        drive_fault(TTYP_UNTR_READ, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 8);
        check_eq("full_o", 1, full_o);     // Four held events fill the FIFO
        drive_fault(TTYP_UNTR_WR, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 0);   // Lost at the FIFO
        repeat (10) @(negedge clk_i);
        check_eq("aw_count", 5, aw_count);
        next_drive();
        fq_head_i = 32'd20;
        fq_of_i   = 1'b0;                   // Software clears the overflow
        wait_writes(11);
        check_eq("fq_tail_i", 9, fq_tail_i);

        // Bus error sets mf and a two-entry queue wraps the tail
        next_drive();
        err_resp = 1'b1;
        drive_fault(TTYP_UNTR_RX, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 9);
        wait_writes(12);
        check_eq("fq_mf_i", 1, fq_mf_i);
        check_eq("fq_tail_i", 9, fq_tail_i);
        next_drive();
        fq_size_i = 5'd0;
        fq_tail_i = 32'd1;
        fq_head_i = 32'd1;
        fq_mf_i   = 1'b0;
        drive_fault(TTYP_UNTR_READ, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1);
        wait_writes(13);
        check_eq("fq_tail_i", 0, fq_tail_i);

        if (exp_addr.size() != 0 || exp_rec.size() != 0) begin
            report_failure("Expected records were never written");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

/* testbench/tb_clk_gen.sv */
//******************************
// Testbench clock and reset
// 20 ns clock, active-low reset held for five cycles
//******************************
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;     // 20 ns period
    end

    initial begin
        rst_no = 1'b0;
        repeat (5) @(posedge clk_o);
        #2 rst_no = 1'b1;               // Released with the other inputs
    end

endmodule

/* source/fq_handler.sv */
//******************************
// Fault queue writer top level
// Faults in as loose fields, records out over AXI write channels
// Register interface for head, tail, mf, of and the enables
//******************************
`timescale 1ns/100ps

module fq_handler import fq_record_pkg::*, fq_axi_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_ni,
    // Queue registers
    input  logic [PPN_W-1:0]   fq_base_ppn_i,
    input  logic [4:0]         fq_size_i,
    input  logic               fq_en_i,
    input  logic               fq_ie_i,
    input  logic [IDX_W-1:0]   fq_head_i,
    input  logic [IDX_W-1:0]   fq_tail_i,
    input  logic               fq_mf_i,
    input  logic               fq_of_i,
    output logic [IDX_W-1:0]   fq_tail_o,
    output logic               fq_mf_o,
    output logic               fq_of_o,
    output logic               error_wen_o,
    output logic               fq_ip_o,
    output logic               fq_on_o,
    output logic               busy_o,
    // Fault event
    input  logic               event_valid_i,
    input  logic [TTYP_W-1:0]  trans_type_i,
    input  logic [CAUSE_W-1:0] cause_code_i,
    input  logic [VLEN-1:0]    iova_i,
    input  logic [GPA_W-1:0]   gpaddr_i,
    input  logic [DID_W-1:0]   did_i,
    input  logic               pv_i,
    input  logic [PID_W-1:0]   pid_i,
    input  logic               is_supervisor_i,
    input  logic               is_guest_pf_i,
    input  logic               is_implicit_i,
    output logic               full_o,
    // AXI write channels
    output logic               aw_valid_o,
    input  logic               aw_ready_i,
    output logic [PLEN-1:0]    aw_addr_o,
    output logic               w_valid_o,
    input  logic               w_ready_i,
    output logic [BEAT_W-1:0]  w_data_o,
    output logic               w_last_o,
    input  logic               b_valid_i,
    output logic               b_ready_o,
    input  logic [1:0]         b_resp_i
);

    logic             evt_valid, evt_ready;
    logic [EVT_W-1:0] evt_data;
    fq_record_t       record, wr_record;
    logic             wr_valid, wr_ready, wr_done, wr_err;
    logic [PLEN-1:0]  wr_addr;

    fq_event_fifo i_fifo (
        .clk_i, .rst_ni, .event_valid_i,
        .event_data_i ({trans_type_i, cause_code_i, iova_i, gpaddr_i, did_i, pv_i, pid_i,
                        is_supervisor_i, is_guest_pf_i, is_implicit_i}),
        .evt_valid_o  (evt_valid), .evt_data_o (evt_data), .evt_ready_i (evt_ready), .full_o
    );

    fq_record_builder i_builder (.evt_data_i (evt_data), .record_o (record));

    fq_queue_ctrl i_ctrl (
        .clk_i, .rst_ni, .fq_base_ppn_i, .fq_size_i, .fq_en_i, .fq_ie_i,
        .fq_head_i, .fq_tail_i, .fq_mf_i, .fq_of_i, .fq_tail_o, .fq_mf_o, .fq_of_o,
        .error_wen_o, .fq_ip_o, .fq_on_o, .busy_o,
        .evt_valid_i (evt_valid), .evt_ready_o (evt_ready), .record_i (record),
        .wr_valid_o  (wr_valid),  .wr_ready_i  (wr_ready),  .wr_addr_o (wr_addr),
        .wr_record_o (wr_record), .wr_done_i   (wr_done),   .wr_err_i  (wr_err)
    );

    fq_axi_writer i_writer (
        .clk_i, .rst_ni,
        .wr_valid_i  (wr_valid),  .wr_ready_o (wr_ready), .wr_addr_i (wr_addr),
        .wr_record_i (wr_record), .wr_done_o  (wr_done),  .wr_err_o  (wr_err),
        .aw_valid_o, .aw_ready_i, .aw_addr_o,
        .w_valid_o, .w_ready_i, .w_data_o, .w_last_o,
        .b_valid_i, .b_ready_o, .b_resp_i
    );

endmodule

/* source/fq_axi_writer.sv */
//******************************
// AXI write sequencer for one fault record
// Sends AW, then four W beats, then waits for B
// Returns wr_done_o with wr_err_o on the response
//******************************
`timescale 1ns/100ps

module fq_axi_writer import fq_record_pkg::*, fq_axi_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              wr_valid_i,
    output logic              wr_ready_o,
    input  logic [PLEN-1:0]   wr_addr_i,
    input  fq_record_t        wr_record_i,
    output logic              wr_done_o,
    output logic              wr_err_o,
    output logic              aw_valid_o,
    input  logic              aw_ready_i,
    output logic [PLEN-1:0]   aw_addr_o,
    output logic              w_valid_o,
    input  logic              w_ready_i,
    output logic [BEAT_W-1:0] w_data_o,
    output logic              w_last_o,
    input  logic              b_valid_i,
    output logic              b_ready_o,
    input  logic [1:0]        b_resp_i
);

    enum logic [1:0] {W_IDLE, W_AW, W_DATA, W_RESP} state_q;

    logic [1:0] beat_q;
    fq_record_t record_q;

    assign wr_ready_o = (state_q == W_IDLE);
    assign aw_valid_o = (state_q == W_AW);
    assign w_valid_o  = (state_q == W_DATA);
    assign b_ready_o  = (state_q == W_RESP);

    assign w_data_o = record_q.beats[beat_q];
    assign w_last_o = w_valid_o & (beat_q == BURST_LEN[1:0]);

    assign wr_done_o = b_ready_o & b_valid_i;
    assign wr_err_o  = wr_done_o & (b_resp_i != RESP_OKAY);    // SLVERR or DECERR

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= W_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                W_IDLE:  if (wr_valid_i) state_q <= W_AW;
                W_AW:    if (aw_ready_i) state_q <= W_DATA;
                W_DATA: begin
                    if (w_ready_i) begin
                        beat_q <= beat_q + 1'b1;         // Wraps to 0 after beat 3
                        if (w_last_o) state_q <= W_RESP;
                    end
                end
                W_RESP:  if (b_valid_i) state_q <= W_IDLE;
                default: state_q <= W_IDLE;
            endcase
        end
    end

    // Address and record for the whole burst
    always_ff @(posedge clk_i) begin
        if (wr_valid_i && wr_ready_o) begin
            aw_addr_o <= wr_addr_i;
            record_q  <= wr_record_i;
        end
    end

endmodule

/* source/fq_queue_ctrl.sv */
//******************************
// Fault queue controller
// Tracks the enable, picks the slot, detects overflow and memory errors
// Hands one record at a time to the AXI writer and advances the tail
//******************************
`timescale 1ns/100ps

module fq_queue_ctrl import fq_record_pkg::*, fq_axi_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic [PPN_W-1:0] fq_base_ppn_i,
    input  logic [4:0]       fq_size_i,      // log2(entries) - 1
    input  logic             fq_en_i,
    input  logic             fq_ie_i,
    input  logic [IDX_W-1:0] fq_head_i,
    input  logic [IDX_W-1:0] fq_tail_i,
    input  logic             fq_mf_i,
    input  logic             fq_of_i,
    output logic [IDX_W-1:0] fq_tail_o,
    output logic             fq_mf_o,
    output logic             fq_of_o,
    output logic             error_wen_o,    // Write strobe for tail, mf and of
    output logic             fq_ip_o,
    output logic             fq_on_o,
    output logic             busy_o,
    input  logic             evt_valid_i,
    output logic             evt_ready_o,
    input  fq_record_t       record_i,
    output logic             wr_valid_o,
    input  logic             wr_ready_i,
    output logic [PLEN-1:0]  wr_addr_o,
    output fq_record_t       wr_record_o,
    input  logic             wr_done_i,
    input  logic             wr_err_i
);

    enum logic [1:0] {IDLE, WRITE, ERROR} state_q, state_n;

    logic             fq_en_q, fq_en_n;
    logic             wr_valid_n;
    logic [IDX_W-1:0] tail_mask, masked_tail, next_tail;
    logic             queue_full;

    assign tail_mask   = ~({IDX_W{1'b1}} << ({1'b0, fq_size_i} + 6'd1));
    assign masked_tail = fq_tail_i & tail_mask;
    assign next_tail   = (masked_tail + 1'b1) & tail_mask;
    assign queue_full  = (next_tail == (fq_head_i & tail_mask));

    assign busy_o      = (fq_en_i != fq_en_q);  // Enable change in progress
    assign fq_on_o     = fq_en_i | fq_en_q;
    assign evt_ready_o = (state_q == IDLE) & fq_en_i & fq_en_q;

    always_comb begin
        state_n     = state_q;
        fq_en_n     = fq_en_q;
        wr_valid_n  = wr_valid_o & ~wr_ready_i;  // Held until the writer takes it
        fq_tail_o   = fq_tail_i;
        fq_mf_o     = fq_mf_i;
        fq_of_o     = fq_of_i;
        error_wen_o = 1'b0;
        fq_ip_o     = 1'b0;
        case (state_q)
            IDLE: begin
                if (fq_en_i && !fq_en_q) begin      // Fresh enable clears the queue state
                    fq_tail_o   = '0;
                    fq_mf_o     = 1'b0;
                    fq_of_o     = 1'b0;
                    error_wen_o = 1'b1;
                    fq_en_n     = 1'b1;
                end else if (!fq_en_i) begin
                    fq_en_n = 1'b0;
                end else if (evt_valid_i) begin     // Event taken this cycle
                    if (queue_full) begin
                        fq_of_o     = 1'b1;         // Record is lost
                        error_wen_o = 1'b1;
                        fq_ip_o     = fq_ie_i;
                        state_n     = ERROR;
                    end else begin
                        wr_valid_n = 1'b1;
                        state_n    = WRITE;
                    end
                end
            end
            WRITE: begin
                if (wr_done_i) begin
                    error_wen_o = 1'b1;
                    fq_ip_o     = fq_ie_i;
                    if (wr_err_i) begin
                        fq_mf_o = 1'b1;             // Tail stays put
                        state_n = ERROR;
                    end else begin
                        fq_tail_o = next_tail;
                        state_n   = IDLE;
                    end
                end
            end
            ERROR:   if (!fq_mf_i && !fq_of_i) state_n = IDLE;  // Software cleared both
            default: state_n = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            fq_en_q    <= 1'b0;
            wr_valid_o <= 1'b0;
        end else begin
            state_q    <= state_n;
            fq_en_q    <= fq_en_n;
            wr_valid_o <= wr_valid_n;
        end
    end

    // Slot address and record, taken with the event
    always_ff @(posedge clk_i) begin
        if (evt_valid_i && evt_ready_o && !queue_full) begin
            wr_addr_o   <= {fq_base_ppn_i, 12'b0}
                         + ({{(PLEN-IDX_W){1'b0}}, masked_tail} << RECORD_SHIFT);
            wr_record_o <= record_i;
        end
    end

endmodule

/* source/fq_record_builder.sv */
//******************************
// Fault record formatter
// Turns the event at the FIFO head into a fault record, no clock
//******************************
`timescale 1ns/100ps

module fq_record_builder import fq_record_pkg::*; (
    input  logic [EVT_W-1:0] evt_data_i,
    output fq_record_t       record_o
);

    logic [TTYP_W-1:0]  ttyp;
    logic [CAUSE_W-1:0] cause;
    logic [VLEN-1:0]    iova;
    logic [GPA_W-1:0]   gpaddr;
    logic [DID_W-1:0]   did;
    logic               pv;
    logic [PID_W-1:0]   pid;
    logic               is_supervisor;
    logic               is_guest_pf;
    logic               is_implicit;

    // Same field order as the top level packs them
    assign {ttyp, cause, iova, gpaddr, did, pv, pid,
            is_supervisor, is_guest_pf, is_implicit} = evt_data_i;

    always_comb begin
        record_o               = '0;
        record_o.fields.ttyp   = ttyp;
        record_o.fields.cause  = cause;
        record_o.fields.iotval = {{(64-VLEN){1'b0}}, iova};  // Reported for every type

        // did, pv, priv and pid stay zero without a transaction
        if (ttyp != TTYP_NONE) begin
            record_o.fields.did  = did;
            record_o.fields.pv   = pv;
            record_o.fields.pid  = pv ? pid : '0;
            record_o.fields.priv = pv & is_supervisor;
        end

        // Guest page fault
        if (is_guest_pf) begin
            record_o.fields.iotval2    = {{(64-GPA_W){1'b0}}, gpaddr};
            record_o.fields.iotval2[0] = is_implicit;   // Implicit first-stage access
            record_o.fields.iotval2[1] = 1'b0;          // No A/D bit update
        end
    end

endmodule

/* source/fq_event_fifo.sv */
//******************************
// Fault event capture FIFO
// Pushes on the rising edge of event_valid_i, drops events when full
// Fall-through: a push into an empty FIFO is at the head at once
//******************************
`timescale 1ns/100ps

module fq_event_fifo import fq_record_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             event_valid_i,
    input  logic [EVT_W-1:0] event_data_i,
    output logic             evt_valid_o,
    output logic [EVT_W-1:0] evt_data_o,
    input  logic             evt_ready_i,
    output logic             full_o
);

    logic                          event_q;     // Last cycle's event_valid_i
    logic                          push, pop, empty;
    logic                          store, take;
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr_q, rd_ptr_q;
    logic [$clog2(FIFO_DEPTH):0]   count_q;
    logic [EVT_W-1:0]              mem_q [FIFO_DEPTH];

    assign empty  = (count_q == '0);
    assign full_o = (count_q == FIFO_DEPTH);

    assign push = event_valid_i & ~event_q & ~full_o;   // Rising edge, room left

    // Head is the input while empty
    assign evt_valid_o = ~empty | push;
    assign evt_data_o  = empty ? event_data_i : mem_q[rd_ptr_q];
    assign pop         = evt_valid_o & evt_ready_i;

    assign store = push & ~(empty & pop);   // Passed straight through otherwise
    assign take  = pop & ~empty;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            event_q  <= 1'b0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            event_q <= event_valid_i;
            if (store) wr_ptr_q <= wr_ptr_q + 1'b1;     // Depth is a power of two
            if (take)  rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({store, take})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (store) mem_q[wr_ptr_q] <= event_data_i;
    end

endmodule

/* source/fq_axi_pkg.sv */
//******************************
// AXI write constants for the fault queue writer
// One record goes out as a single INCR burst of four 64-bit beats
//******************************
package fq_axi_pkg;

    localparam int unsigned BEAT_W = 64;       // W data width

    localparam logic [7:0] BURST_LEN = 8'd3;   // AWLEN, four beats
    localparam logic [2:0] BEAT_SIZE = 3'd3;   // AWSIZE, 8 bytes per beat

    // Record step in bytes as a shift, beat bytes times beat count
    localparam int unsigned RECORD_SHIFT = int'(BEAT_SIZE) + $clog2(int'(BURST_LEN) + 1);

    // B channel response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_EXOKAY = 2'b01;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] RESP_DECERR = 2'b11;

endpackage

/* source/fq_record_pkg.sv */
//******************************
// Fault record definitions for the IOMMU fault queue writer
// Field widths, transaction types and the 32-byte record layout
// Import with a wildcard in the module header
//******************************
package fq_record_pkg;

    // Field widths
    localparam int unsigned PPN_W   = 44;   // Queue base page number
    localparam int unsigned PLEN    = 56;   // Physical address
    localparam int unsigned VLEN    = 39;   // IOVA
    localparam int unsigned GPA_W   = 41;   // Guest address bits 63:2
    localparam int unsigned DID_W   = 24;
    localparam int unsigned PID_W   = 20;
    localparam int unsigned CAUSE_W = 12;
    localparam int unsigned TTYP_W  = 6;
    localparam int unsigned IDX_W   = 32;   // Head and tail indexes

    localparam int unsigned FIFO_DEPTH = 4;  // Pending fault events

    // Packed event, four flags are pv, supervisor, guest pf and implicit
    localparam int unsigned EVT_W = TTYP_W + CAUSE_W + VLEN + GPA_W + DID_W + PID_W + 4;

    // Transaction types
    localparam logic [TTYP_W-1:0] TTYP_NONE      = TTYP_W'(0);  // No transaction, MSI write fault
    localparam logic [TTYP_W-1:0] TTYP_UNTR_RX   = TTYP_W'(1);  // Untranslated read for execute
    localparam logic [TTYP_W-1:0] TTYP_UNTR_READ = TTYP_W'(2);
    localparam logic [TTYP_W-1:0] TTYP_UNTR_WR   = TTYP_W'(3);  // Untranslated write or AMO

    // One fault record, seen as fields or as the four bus beats
    typedef union packed {
        struct packed {
            logic [63:0]        iotval2;
            logic [63:0]        iotval;
            logic [31:0]        custom;     // Left for custom use, written as zero
            logic [31:0]        reserved;
            logic [DID_W-1:0]   did;
            logic [TTYP_W-1:0]  ttyp;
            logic               priv;
            logic               pv;
            logic [PID_W-1:0]   pid;
            logic [CAUSE_W-1:0] cause;      // Lowest bits of beat 0
        } fields;
        logic [3:0][63:0] beats;            // Beat 0 at bits 63:0
    } fq_record_t;

endpackage
